// File: src/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  exccode_t;
    typedef logic [3:0]  buf_ptr_t;
    typedef logic [3:0]  line_count_t;

    typedef enum logic [3:0] {
        wait_preif   = 4'b0001,
        recv_inst    = 4'b0010,
        recv_no_inst = 4'b0100,
        clear_all    = 4'b1000
    } fetch_state_t;

    localparam int BUF_DEPTH           = 16;
    localparam int LINE_WORDS          = 8;
    localparam int MAX_FILL_BEFORE_REQ = 7;
    localparam int NO_INST_WORDS       = 2;
    localparam int ISSUE_WIDTH         = 2;
    localparam logic [5:0] RESET_OFFSET = 6'd4;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_REGIMM   = 6'h01;
    localparam logic [5:0] OP_J        = 6'h02;
    localparam logic [5:0] OP_JAL      = 6'h03;
    localparam logic [5:0] OP_BEQ      = 6'h04;
    localparam logic [5:0] OP_BNE      = 6'h05;
    localparam logic [5:0] OP_BLEZ     = 6'h06;
    localparam logic [5:0] OP_BGTZ     = 6'h07;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [5:0] OP_COP0     = 6'h10;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_LB       = 6'h20;
    localparam logic [5:0] OP_LH       = 6'h21;
    localparam logic [5:0] OP_LWL      = 6'h22;
    localparam logic [5:0] OP_LW       = 6'h23;
    localparam logic [5:0] OP_LBU      = 6'h24;
    localparam logic [5:0] OP_LHU      = 6'h25;
    localparam logic [5:0] OP_LWR      = 6'h26;
    localparam logic [5:0] OP_SB       = 6'h28;
    localparam logic [5:0] OP_SH       = 6'h29;
    localparam logic [5:0] OP_SWL      = 6'h2a;
    localparam logic [5:0] OP_SW       = 6'h2b;
    localparam logic [5:0] OP_SWR      = 6'h2e;

    // function field of SPECIAL / SPECIAL2
    localparam logic [5:0] FN_SLL   = 6'h00;
    localparam logic [5:0] FN_SRL   = 6'h02;
    localparam logic [5:0] FN_SRA   = 6'h03;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_JALR  = 6'h09;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV   = 6'h1a;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_MUL   = 6'h02;

    // rs field of COP0
    localparam reg_addr_t COP0_MF = 5'd0;
    localparam reg_addr_t COP0_MT = 5'd4;

endpackage

// File: src/fetch_control.sv
`timescale 1ns/1ps

module fetch_control import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        to_fs_valid,
    input  logic        fs_no_inst_wait,
    input  logic        flush,
    input  logic        inst_cache_data_ok,
    input  line_count_t inst_cache_data_num,
    input  logic        buf_room,
    input  logic        buf_ready,
    input  logic        ds_allowin,
    output logic        fs_allowin,
    output logic [5:0]  fs_to_preif_offset,
    output logic        fs_to_ds_valid,
    output logic        pop,
    output logic        line_write,
    output logic        no_inst_write,
    output logic        fetch_accept
);

    fetch_state_t state;

    assign fs_allowin   = (state == wait_preif) && buf_room;
    assign fetch_accept = to_fs_valid && fs_allowin;

    // a flush in the same cycle drops whatever would be written
    assign line_write    = (state == recv_inst) && inst_cache_data_ok && !flush;
    assign no_inst_write = (state == recv_no_inst) && !flush;

    assign fs_to_ds_valid = buf_ready && (state != clear_all) && !flush;
    assign pop            = fs_to_ds_valid && ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= wait_preif;
        end else begin
            case (state)
                wait_preif: begin
                    if (fetch_accept) begin
                        state <= fs_no_inst_wait ? recv_no_inst : recv_inst;
                    end
                end
                recv_inst: begin
                    if (inst_cache_data_ok) begin
                        state <= wait_preif;
                    end else if (flush) begin
                        state <= clear_all;
                    end
                end
                recv_no_inst: begin
                    state <= wait_preif;
                end
                clear_all: begin
                    // outstanding line is thrown away
                    if (inst_cache_data_ok) begin
                        state <= wait_preif;
                    end
                end
                default: begin
                    state <= wait_preif;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            fs_to_preif_offset <= RESET_OFFSET;
        end else if (line_write) begin
            fs_to_preif_offset <= {inst_cache_data_num, 2'b00};
        end
    end

endmodule

// File: src/inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer import fetch_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   fetch_accept,
    input  word_t                  pf_pc,
    input  logic                   pf_except,
    input  exccode_t               pf_exccode,
    input  logic                   pf_refill,
    input  logic                   line_write,
    input  logic                   no_inst_write,
    input  line_count_t            inst_cache_data_num,
    input  word_t [LINE_WORDS-1:0] inst_cache_rdata,
    input  logic                   pop,
    input  logic                   pop_two,
    output logic                   buf_room,
    output logic                   buf_ready,
    output word_t                  rd1_inst,
    output word_t                  rd1_pc,
    output logic                   rd1_except,
    output exccode_t               rd1_exccode,
    output logic                   rd1_refill,
    output word_t                  rd2_inst,
    output word_t                  rd2_pc,
    output logic                   rd2_except,
    output exccode_t               rd2_exccode,
    output logic                   rd2_refill
);

    // fields of the request in flight
    word_t    req_pc;
    logic     req_except;
    exccode_t req_exccode;
    logic     req_refill;

    word_t    buf_inst    [BUF_DEPTH];
    word_t    buf_pc      [BUF_DEPTH];
    logic     buf_except  [BUF_DEPTH];
    exccode_t buf_exccode [BUF_DEPTH];
    logic     buf_refill  [BUF_DEPTH];

    buf_ptr_t head;
    buf_ptr_t tail;
    buf_ptr_t head_next;
    buf_ptr_t fill;
    buf_ptr_t wr_ptr [LINE_WORDS];
    word_t    wr_pc  [LINE_WORDS];

    always_ff @(posedge clk) begin
        if (fetch_accept) begin
            req_pc      <= pf_pc;
            req_except  <= pf_except;
            req_exccode <= pf_exccode;
            req_refill  <= pf_refill;
        end
    end

    always_comb begin
        for (int i = 0; i < LINE_WORDS; i++) begin
            wr_ptr[i] = tail + buf_ptr_t'(i);
            wr_pc[i]  = req_pc + word_t'(4 * i);
        end
    end

    // whole line goes in, tail only covers data_num of it
    always_ff @(posedge clk) begin
        for (int i = 0; i < LINE_WORDS; i++) begin
            if (line_write || (no_inst_write && i < NO_INST_WORDS)) begin
                buf_inst[wr_ptr[i]]    <= line_write ? inst_cache_rdata[i] : '0;
                buf_pc[wr_ptr[i]]      <= wr_pc[i];
                buf_except[wr_ptr[i]]  <= req_except;
                buf_exccode[wr_ptr[i]] <= req_exccode;
                buf_refill[wr_ptr[i]]  <= req_refill;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            tail <= '0;
        end else if (line_write) begin
            tail <= tail + inst_cache_data_num;
        end else if (no_inst_write) begin
            tail <= tail + buf_ptr_t'(NO_INST_WORDS);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
        end else if (pop) begin
            head <= pop_two ? head + 4'd2 : head + 4'd1;
        end
    end

    assign fill      = tail - head;
    assign buf_room  = fill <= buf_ptr_t'(MAX_FILL_BEFORE_REQ);
    assign buf_ready = fill >= buf_ptr_t'(ISSUE_WIDTH);
    assign head_next = head + 4'd1;

    assign rd1_inst    = buf_inst[head];
    assign rd1_pc      = buf_pc[head];
    assign rd1_except  = buf_except[head];
    assign rd1_exccode = buf_exccode[head];
    assign rd1_refill  = buf_refill[head];

    assign rd2_inst    = buf_inst[head_next];
    assign rd2_pc      = buf_pc[head_next];
    assign rd2_except  = buf_except[head_next];
    assign rd2_exccode = buf_exccode[head_next];
    assign rd2_refill  = buf_refill[head_next];

endmodule

// File: src/inst_predecode.sv
`timescale 1ns/1ps

module inst_predecode import fetch_pkg::*; (
    input  word_t     inst,
    output logic      is_branch,
    output logic      is_muldiv,
    output logic      writes_late,
    output reg_addr_t dest,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output logic      reads_rs,
    output logic      reads_rt
);

    logic [5:0] op;
    logic [5:0] fn;
    reg_addr_t  rd;
    logic       special;
    logic       regimm_br;
    logic       cond_br;
    logic       jump_imm;
    logic       jump_reg;
    logic       load;
    logic       load_partial;
    logic       store;
    logic       alu_imm;
    logic       shift_imm;
    logic       hilo_read;
    logic       hilo_write;
    logic       mul_div;
    logic       mul;
    logic       mfc0;
    logic       mtc0;

    assign op = inst[31:26];
    assign rs = inst[25:21];
    assign rt = inst[20:16];
    assign rd = inst[15:11];
    assign fn = inst[5:0];

    assign special = op == OP_SPECIAL;

    // bltz, bgez, bltzal, bgezal
    assign regimm_br = (op == OP_REGIMM) && (rt[3:1] == 3'b000);
    assign cond_br   = (op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ}) || regimm_br;
    assign jump_imm  = op inside {OP_J, OP_JAL};
    assign jump_reg  = special && (fn inside {FN_JR, FN_JALR});

    assign load         = op inside {OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR};
    assign load_partial = op inside {OP_LWL, OP_LWR};
    assign store        = op inside {OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR};

    // addi .. xori, lui has no source
    assign alu_imm   = (op[5:3] == 3'b001) && (op != OP_LUI);
    assign shift_imm = special && (fn inside {FN_SLL, FN_SRL, FN_SRA});

    assign hilo_read  = special && (fn inside {FN_MFHI, FN_MFLO});
    assign hilo_write = special && (fn inside {FN_MTHI, FN_MTLO});
    assign mul_div    = special && (fn inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});
    assign mul        = (op == OP_SPECIAL2) && (fn == FN_MUL);

    assign mfc0 = (op == OP_COP0) && (rs == COP0_MF);
    assign mtc0 = (op == OP_COP0) && (rs == COP0_MT);

    assign is_branch   = cond_br || jump_imm || jump_reg;
    assign is_muldiv   = mul_div || mul;
    assign writes_late = load || mfc0 || hilo_read;

    // mfhi/mflo write rd, loads and mfc0 write rt
    assign dest = hilo_read ? rd : rt;

    assign reads_rs = cond_br || load || store || alu_imm || mul ||
                      (special && !shift_imm && !hilo_read);

    assign reads_rt = (op inside {OP_BEQ, OP_BNE}) || store || load_partial || mul || mtc0 ||
                      (special && !jump_reg && !hilo_read && !hilo_write);

endmodule

// File: src/issue_pair.sv
`timescale 1ns/1ps

module issue_pair import fetch_pkg::*; (
    input  logic      inst1_writes_late,
    input  reg_addr_t inst1_dest,
    input  logic      inst1_is_muldiv,
    input  logic      slot2_is_branch,
    input  logic      slot2_is_muldiv,
    input  reg_addr_t slot2_rs,
    input  reg_addr_t slot2_rt,
    input  logic      slot2_reads_rs,
    input  logic      slot2_reads_rt,
    input  word_t     slot2_inst,
    input  logic      slot2_except,
    input  exccode_t  slot2_exccode,
    input  logic      slot2_refill,
    output logic      inst2_valid,
    output logic      pop_two,
    output word_t     inst2_inst,
    output logic      inst2_except,
    output exccode_t  inst2_exccode,
    output logic      inst2_refill
);

    logic rs_match;
    logic rt_match;
    logic late_dep;

    // $0 never creates a dependency
    assign rs_match = slot2_reads_rs && (slot2_rs != '0) && (slot2_rs == inst1_dest);
    assign rt_match = slot2_reads_rt && (slot2_rt != '0) && (slot2_rt == inst1_dest);
    assign late_dep = inst1_writes_late && (rs_match || rt_match);

    assign inst2_valid = !(late_dep || slot2_is_branch || (inst1_is_muldiv && slot2_is_muldiv));
    assign pop_two     = inst2_valid;

    assign inst2_inst    = inst2_valid ? slot2_inst : '0;
    assign inst2_except  = inst2_valid && slot2_except;
    assign inst2_exccode = inst2_valid ? slot2_exccode : '0;
    assign inst2_refill  = inst2_valid && slot2_refill;

endmodule

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   to_fs_valid,
    input  logic                   fs_no_inst_wait,
    input  word_t                  pf_pc,
    input  logic                   pf_except,
    input  exccode_t               pf_exccode,
    input  logic                   pf_refill,
    output logic                   fs_allowin,
    output logic [5:0]             fs_to_preif_offset,
    input  logic                   inst_cache_data_ok,
    input  line_count_t            inst_cache_data_num,
    input  word_t [LINE_WORDS-1:0] inst_cache_rdata,
    input  logic                   ds_allowin,
    output logic                   fs_to_ds_valid,
    output word_t                  inst1_inst,
    output word_t                  inst1_pc,
    output logic                   inst1_except,
    output exccode_t               inst1_exccode,
    output logic                   inst1_refill,
    output logic                   inst2_valid,
    output word_t                  inst2_inst,
    output word_t                  inst2_pc,
    output logic                   inst2_except,
    output exccode_t               inst2_exccode,
    output logic                   inst2_refill,
    input  logic                   flush
);

    logic      buf_room;
    logic      buf_ready;
    logic      pop;
    logic      pop_two;
    logic      line_write;
    logic      no_inst_write;
    logic      fetch_accept;
    word_t     rd2_inst;
    logic      rd2_except;
    exccode_t  rd2_exccode;
    logic      rd2_refill;

    word_t     pd_inst        [ISSUE_WIDTH];
    logic      pd_is_branch   [ISSUE_WIDTH];
    logic      pd_is_muldiv   [ISSUE_WIDTH];
    logic      pd_writes_late [ISSUE_WIDTH];
    reg_addr_t pd_dest        [ISSUE_WIDTH];
    reg_addr_t pd_rs          [ISSUE_WIDTH];
    reg_addr_t pd_rt          [ISSUE_WIDTH];
    logic      pd_reads_rs    [ISSUE_WIDTH];
    logic      pd_reads_rt    [ISSUE_WIDTH];

    fetch_control u_control (
        .clk, .reset, .to_fs_valid, .fs_no_inst_wait, .flush,
        .inst_cache_data_ok, .inst_cache_data_num, .buf_room, .buf_ready, .ds_allowin,
        .fs_allowin, .fs_to_preif_offset, .fs_to_ds_valid, .pop,
        .line_write, .no_inst_write, .fetch_accept
    );

    inst_buffer u_buffer (
        .clk, .reset, .flush, .fetch_accept,
        .pf_pc, .pf_except, .pf_exccode, .pf_refill,
        .line_write, .no_inst_write, .inst_cache_data_num, .inst_cache_rdata,
        .pop, .pop_two, .buf_room, .buf_ready,
        .rd1_inst(inst1_inst), .rd1_pc(inst1_pc), .rd1_except(inst1_except),
        .rd1_exccode(inst1_exccode), .rd1_refill(inst1_refill),
        .rd2_inst, .rd2_pc(inst2_pc), .rd2_except, .rd2_exccode, .rd2_refill
    );

    assign pd_inst[0] = inst1_inst;
    assign pd_inst[1] = rd2_inst;

    for (genvar s = 0; s < ISSUE_WIDTH; s++) begin : g_predecode
        inst_predecode u_predecode (
            .inst(pd_inst[s]), .is_branch(pd_is_branch[s]), .is_muldiv(pd_is_muldiv[s]),
            .writes_late(pd_writes_late[s]), .dest(pd_dest[s]), .rs(pd_rs[s]),
            .rt(pd_rt[s]), .reads_rs(pd_reads_rs[s]), .reads_rt(pd_reads_rt[s])
        );
    end

    issue_pair u_pair (
        .inst1_writes_late(pd_writes_late[0]), .inst1_dest(pd_dest[0]),
        .inst1_is_muldiv(pd_is_muldiv[0]),
        .slot2_is_branch(pd_is_branch[1]), .slot2_is_muldiv(pd_is_muldiv[1]),
        .slot2_rs(pd_rs[1]), .slot2_rt(pd_rt[1]),
        .slot2_reads_rs(pd_reads_rs[1]), .slot2_reads_rt(pd_reads_rt[1]),
        .slot2_inst(rd2_inst), .slot2_except(rd2_except),
        .slot2_exccode(rd2_exccode), .slot2_refill(rd2_refill),
        .inst2_valid, .pop_two, .inst2_inst, .inst2_except, .inst2_exccode, .inst2_refill
    );

endmodule

// File: include/fetch_stage_tests.svh
function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt, input reg_addr_t rd,
                                 input logic [5:0] fn);
    return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt,
                                 input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// addu $(first+i), $1, $2 so that no word depends on another
function automatic line_t addu_line(input int first);
    line_t words;
    for (int i = 0; i < LINE_WORDS; i++) begin
        words[i] = r_type(5'd1, 5'd2, reg_addr_t'(first + i), ADDU_FN);
    end
    return words;
endfunction

task automatic send_request(input word_t pc, input logic no_inst, input logic exc,
                            input exccode_t code, input logic refill);
    #SETTLE;
    while (!fs_allowin) begin
        @(negedge clk);
        #SETTLE;
    end
    @(negedge clk);
    to_fs_valid     = 1'b1;
    fs_no_inst_wait = no_inst;
    pf_pc           = pc;
    pf_except       = exc;
    pf_exccode      = code;
    pf_refill       = refill;
    @(negedge clk);
    to_fs_valid     = 1'b0;
    fs_no_inst_wait = 1'b0;
endtask

// cache reply after 1 to 4 cycles
task automatic send_line(input line_t words, input line_count_t num);
    int delay;
    delay = random_bits(2);
    @(negedge clk);
    repeat (delay) @(negedge clk);
    inst_cache_data_ok  = 1'b1;
    inst_cache_data_num = num;
    inst_cache_rdata    = words;
    @(negedge clk);
    inst_cache_data_ok  = 1'b0;
endtask

task automatic take_issue(input word_t i1, input word_t p1, input logic v2, input word_t i2,
                          input logic exc, input exccode_t code, input logic refill);
    #SETTLE;
    while (!fs_to_ds_valid) begin
        @(negedge clk);
        #SETTLE;
    end
    check_word("inst1_inst", i1, inst1_inst);
    check_word("inst1_pc", p1, inst1_pc);
    check_bit("inst1_except", exc, inst1_except);
    check_code("inst1_exccode", code, inst1_exccode);
    check_bit("inst1_refill", refill, inst1_refill);
    check_bit("inst2_valid", v2, inst2_valid);
    check_word("inst2_inst", v2 ? i2 : '0, inst2_inst);
    if (v2) begin
        check_word("inst2_pc", p1 + 32'd4, inst2_pc);
    end
    check_bit("inst2_except", v2 && exc, inst2_except);
    check_code("inst2_exccode", v2 ? code : '0, inst2_exccode);
    check_bit("inst2_refill", v2 && refill, inst2_refill);
    @(negedge clk);
    ds_allowin = 1'b1;
    @(negedge clk);
    ds_allowin = 1'b0;
endtask

task automatic after_reset();
    current_test = "after_reset";
    #SETTLE;
    check_bit("fs_to_ds_valid", 1'b0, fs_to_ds_valid);
    check_bit("fs_allowin", 1'b1, fs_allowin);
    check_offset("offset", 6'd4, fs_to_preif_offset);
endtask

task automatic full_line_pairs();
    line_t words;
    word_t base;
    current_test = "full_line_pairs";
    base  = 32'hbfc0_0000;
    words = addu_line(8);
    send_request(base, 1'b0, 1'b0, '0, 1'b0);
    send_line(words, 4'd8);
    for (int i = 0; i < LINE_WORDS; i += 2) begin
        take_issue(words[i], base + word_t'(4 * i), 1'b1, words[i + 1], 1'b0, '0, 1'b0);
    end
    #SETTLE;
    check_offset("offset", 6'd32, fs_to_preif_offset);
    check_bit("empty_valid", 1'b0, fs_to_ds_valid);
endtask

task automatic pairing_cuts();
    line_t words;
    line_t tail_words;
    word_t base;
    current_test = "pairing_cuts";
    base     = 32'h0000_1000;
    words[0] = i_type(OP_LW, 5'd1, 5'd5, 16'd0);
    words[1] = r_type(5'd5, 5'd2, 5'd6, ADDU_FN);
    words[2] = r_type(5'd3, 5'd4, 5'd7, ADDU_FN);
    words[3] = r_type(5'd3, 5'd4, 5'd8, ADDU_FN);
    words[4] = i_type(OP_BEQ, 5'd1, 5'd2, 16'd4);
    words[5] = r_type(5'd3, 5'd4, 5'd9, ADDU_FN);
    words[6] = r_type(5'd1, 5'd2, 5'd0, FN_MULT);
    words[7] = r_type(5'd3, 5'd4, 5'd0, FN_DIV);
    tail_words    = '0;
    tail_words[0] = r_type(5'd3, 5'd4, 5'd10, ADDU_FN);
    // requests carry exception fields so a cut slot 2 must zero them
    send_request(base, 1'b0, 1'b1, 5'h02, 1'b1);
    send_line(words, 4'd8);
    // load then dependent addu
    take_issue(words[0], base, 1'b0, '0, 1'b1, 5'h02, 1'b1);
    take_issue(words[1], base + 32'd4, 1'b1, words[2], 1'b1, 5'h02, 1'b1);
    // branch in slot 2
    take_issue(words[3], base + 32'd12, 1'b0, '0, 1'b1, 5'h02, 1'b1);
    take_issue(words[4], base + 32'd16, 1'b1, words[5], 1'b1, 5'h02, 1'b1);
    // mult then div
    take_issue(words[6], base + 32'd24, 1'b0, '0, 1'b1, 5'h02, 1'b1);
    send_request(base + 32'd32, 1'b0, 1'b1, 5'h02, 1'b1);
    send_line(tail_words, 4'd1);
    take_issue(words[7], base + 32'd28, 1'b1, tail_words[0], 1'b1, 5'h02, 1'b1);
    #SETTLE;
    check_offset("offset", 6'd4, fs_to_preif_offset);
endtask

task automatic no_inst_request();
    word_t base;
    current_test = "no_inst_request";
    base = 32'h0000_4000;
    send_request(base, 1'b1, 1'b1, 5'h02, 1'b1);
    take_issue('0, base, 1'b1, '0, 1'b1, 5'h02, 1'b1);
    #SETTLE;
    check_bit("empty_valid", 1'b0, fs_to_ds_valid);
endtask

task automatic flush_in_recv();
    line_t first_words;
    line_t late_words;
    line_t new_words;
    word_t base;
    current_test = "flush_in_recv";
    base        = 32'h0000_2000;
    first_words = addu_line(12);
    late_words  = addu_line(20);
    new_words   = addu_line(24);
    send_request(base, 1'b0, 1'b0, '0, 1'b0);
    send_line(first_words, 4'd4);
    #SETTLE;
    check_offset("offset_before", 6'd16, fs_to_preif_offset);
    send_request(base + 32'd16, 1'b0, 1'b0, '0, 1'b0);
    flush = 1'b1;
    #SETTLE;
    check_bit("valid_during_flush", 1'b0, fs_to_ds_valid);
    @(negedge clk);
    flush = 1'b0;
    #SETTLE;
    check_offset("offset_after", 6'd4, fs_to_preif_offset);
    check_bit("allowin_clear", 1'b0, fs_allowin);
    check_bit("valid_clear", 1'b0, fs_to_ds_valid);
    send_line(late_words, 4'd8);
    repeat (3) begin
        #SETTLE;
        check_bit("valid_after_late", 1'b0, fs_to_ds_valid);
        check_offset("offset_after_late", 6'd4, fs_to_preif_offset);
        @(negedge clk);
    end
    send_request(base + 32'h100, 1'b0, 1'b0, '0, 1'b0);
    send_line(new_words, 4'd2);
    take_issue(new_words[0], base + 32'h100, 1'b1, new_words[1], 1'b0, '0, 1'b0);
endtask

task automatic back_pressure();
    line_t words;
    word_t base;
    current_test = "back_pressure";
    base  = 32'h0000_3000;
    words = addu_line(16);
    send_request(base, 1'b0, 1'b0, '0, 1'b0);
    send_line(words, 4'd4);
    repeat (5) begin
        #SETTLE;
        check_bit("valid_held", 1'b1, fs_to_ds_valid);
        check_word("inst1_held", words[0], inst1_inst);
        check_word("pc1_held", base, inst1_pc);
        check_word("inst2_held", words[1], inst2_inst);
        check_word("pc2_held", base + 32'd4, inst2_pc);
        @(negedge clk);
    end
    take_issue(words[0], base, 1'b1, words[1], 1'b0, '0, 1'b0);
    take_issue(words[2], base + 32'd8, 1'b1, words[3], 1'b0, '0, 1'b0);
endtask

// File: verification/fetch_stage_tb.sv
`timescale 1ns/1ps

module fetch_stage_tb import fetch_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int SETTLE     = 5;
    localparam int NUM_TESTS  = 6;
    localparam logic [5:0] ADDU_FN = 6'h21;

    typedef word_t [LINE_WORDS-1:0] line_t;

    logic        clk;
    logic        reset;
    logic        to_fs_valid;
    logic        fs_no_inst_wait;
    word_t       pf_pc;
    logic        pf_except;
    exccode_t    pf_exccode;
    logic        pf_refill;
    logic        fs_allowin;
    logic [5:0]  fs_to_preif_offset;
    logic        inst_cache_data_ok;
    line_count_t inst_cache_data_num;
    line_t       inst_cache_rdata;
    logic        ds_allowin;
    logic        fs_to_ds_valid;
    word_t       inst1_inst;
    word_t       inst1_pc;
    logic        inst1_except;
    exccode_t    inst1_exccode;
    logic        inst1_refill;
    logic        inst2_valid;
    word_t       inst2_inst;
    word_t       inst2_pc;
    logic        inst2_except;
    exccode_t    inst2_exccode;
    logic        inst2_refill;
    logic        flush;

    string       current_test = "startup";
    int          checks = 0;
    int          errors = 0;
    logic [15:0] lfsr_state = 16'd31;

    fetch_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hb400;
        end
        return out;
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_bit());
        end
        return value;
    endfunction

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", current_test, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s %s: expected %b, actual %b", current_test, what, expected, actual);
        end
    endtask

    task automatic check_code(input string what, input exccode_t expected, input exccode_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", current_test, what, expected, actual);
        end
    endtask

    task automatic check_offset(input string what, input logic [5:0] expected,
                                input logic [5:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s %s: expected %0d, actual %0d", current_test, what, expected,
                     actual);
        end
    endtask

    `include "fetch_stage_tests.svh"

    initial begin
        reset               = 1'b1;
        to_fs_valid         = 1'b0;
        fs_no_inst_wait     = 1'b0;
        pf_pc               = '0;
        pf_except           = 1'b0;
        pf_exccode          = '0;
        pf_refill           = 1'b0;
        inst_cache_data_ok  = 1'b0;
        inst_cache_data_num = '0;
        inst_cache_rdata    = '0;
        ds_allowin          = 1'b0;
        flush               = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        after_reset();
        full_line_pairs();
        pairing_cuts();
        no_inst_request();
        flush_in_recv();
        back_pressure();

        @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("watchdog expired, test %s never finished", current_test);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: fetch_stage.f
+incdir+include
src/fetch_pkg.sv
src/fetch_control.sv
src/inst_buffer.sv
src/inst_predecode.sv
src/issue_pair.sv
src/fetch_stage.sv
verification/fetch_stage_tb.sv

// File: Bender.yml
package:
  name: fetch_stage

sources:
  - files:
      - src/fetch_pkg.sv
      - src/fetch_control.sv
      - src/inst_buffer.sv
      - src/inst_predecode.sv
      - src/issue_pair.sv
      - src/fetch_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/fetch_stage_tb.sv
